/* verilog/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and register file geometry
`define DATA_W 32
`define REG_CNT 32
`define REG_AW 5

// exception causes, MIPS Cause.ExcCode values
`define EXC_OV 5'd12
`define EXC_RI 5'd10

`endif

/* verilog/corePkg.sv */
`include "core_macros.svh"

package corePkg;

	// operation carried from decode to execute
	typedef enum logic [3:0] {
		opAdd,  // ADD, ADDI
		opAddu,
		opSub,
		opAnd,
		opOr,   // OR, ORI
		opXor,
		opSlt,
		opSll,
		opLui,
		opNone  // reserved encodings
	} aluOp_t;

	typedef enum logic [4:0] {
		excNone = 5'd0,
		excOv = `EXC_OV,
		excRi = `EXC_RI
	} excCode_t;

endpackage

/* verilog/stageBus.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

// decode -> execute bundle
interface decodeBus;
	import corePkg::*;

	logic valid;
	aluOp_t op;
	logic [`REG_AW-1:0] dest;
	logic [`REG_AW-1:0] srcA;
	logic [`REG_AW-1:0] srcB;
	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;
	logic trapsOv; // ADD, SUB, ADDI
	logic ri;
	logic [`DATA_W-1:0] pc;

	modport src (output valid, op, dest, srcA, srcB, opA, opB, trapsOv, ri, pc);
	modport dst (input valid, op, dest, srcA, srcB, opA, opB, trapsOv, ri, pc);
endinterface

// execute -> result bundle
interface resultBus;
	import corePkg::*;

	logic valid;
	logic [`REG_AW-1:0] dest;
	logic [`DATA_W-1:0] value;
	excCode_t exc;
	logic [`DATA_W-1:0] pc;

	modport src (output valid, dest, value, exc, pc);
	modport dst (input valid, dest, value, exc, pc);
endinterface

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module decodeStage (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [`DATA_W-1:0] instr,
	input logic [`DATA_W-1:0] pc,
	input logic squash,
	input logic wrEn,
	input logic [`REG_AW-1:0] wrAddr,
	input logic [`DATA_W-1:0] wrData,
	decodeBus.src dBus
);
	import corePkg::*;

	logic [`DATA_W-1:0] regs [`REG_CNT];
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`REG_AW-1:0] rd;
	logic [4:0] shamt;
	logic [15:0] imm;
	aluOp_t op;
	logic ri;
	logic trapsOv;
	logic isImm;
	logic isShift;
	logic signExt;
	logic [`DATA_W-1:0] immExt;
	logic [`DATA_W-1:0] rsVal;
	logic [`DATA_W-1:0] rtVal;
	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;
	logic [`REG_AW-1:0] srcA;
	logic [`REG_AW-1:0] srcB;
	logic [`REG_AW-1:0] dest;
	logic squashDly;

	// r0 reads zero, same-cycle write is passed through
	function automatic logic [`DATA_W-1:0] readReg(input logic [`REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		if (wrEn && wrAddr == addr)
			return wrData;
		return regs[addr];
	endfunction

	always_ff @(posedge clk)
		if (wrEn && wrAddr != '0)
			regs[wrAddr] <= wrData;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];
	assign imm = instr[15:0];

	always_comb begin
		op = opNone;
		ri = 1'b0;
		trapsOv = 1'b0;
		isImm = 1'b0;
		isShift = 1'b0;
		signExt = 1'b0;
		case (opcode)
			6'h00: begin
				case (funct)
					6'h20: begin op = opAdd; trapsOv = 1'b1; end
					6'h21: op = opAddu;
					6'h22: begin op = opSub; trapsOv = 1'b1; end
					6'h24: op = opAnd;
					6'h25: op = opOr;
					6'h26: op = opXor;
					6'h2a: op = opSlt;
					6'h00: begin op = opSll; isShift = 1'b1; end
					default: ri = 1'b1;
				endcase
			end
			6'h08: begin op = opAdd; trapsOv = 1'b1; isImm = 1'b1; signExt = 1'b1; end // ADDI
			6'h0d: begin op = opOr; isImm = 1'b1; end // ORI
			6'h0f: begin op = opLui; isImm = 1'b1; end
			default: ri = 1'b1;
		endcase
	end

	assign immExt = {{16{signExt & imm[15]}}, imm};
	always_comb rsVal = readReg(rs);
	always_comb rtVal = readReg(rt);

	always_comb begin
		opA = rsVal;
		srcA = rs;
		opB = rtVal;
		srcB = rt;
		dest = rd;
		if (isShift) begin
			opA = {{(`DATA_W-5){1'b0}}, shamt};
			srcA = '0;
		end else if (isImm) begin
			opB = immExt;
			srcB = '0; // immediate, never bypassed
			dest = rt;
		end
		if (ri)
			dest = '0;
	end

	// an exception also kills whatever enters one edge after the squash
	always_ff @(posedge clk)
		if (!rst)
			squashDly <= 1'b0;
		else
			squashDly <= squash;

	always_ff @(posedge clk)
		if (!rst || squash || squashDly) begin
			dBus.valid <= 1'b0;
			dBus.op <= opNone;
			dBus.dest <= '0;
			dBus.srcA <= '0;
			dBus.srcB <= '0;
			dBus.opA <= '0;
			dBus.opB <= '0;
			dBus.trapsOv <= 1'b0;
			dBus.ri <= 1'b0;
			dBus.pc <= '0;
		end else begin
			dBus.valid <= instrValid;
			dBus.op <= op;
			dBus.dest <= dest;
			dBus.srcA <= srcA;
			dBus.srcB <= srcB;
			dBus.opA <= opA;
			dBus.opB <= opB;
			dBus.trapsOv <= trapsOv;
			dBus.ri <= ri;
			dBus.pc <= pc;
		end

	noZeroWrite: assert property (@(posedge clk) disable iff (!rst) wrEn |-> wrAddr != '0)
		else $error("write to r0 requested");

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module executeStage (
	input logic clk,
	input logic rst,
	decodeBus.dst dBus,
	input logic squash,
	input logic wrEn,
	input logic [`REG_AW-1:0] wrAddr,
	input logic [`DATA_W-1:0] wrData,
	resultBus.src rBus
);
	import corePkg::*;

	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;
	logic [`DATA_W-1:0] sum;
	logic [`DATA_W-1:0] diff;
	logic addOv;
	logic subOv;
	logic ovf;
	logic [`DATA_W-1:0] aluOut;
	excCode_t excNext;

	// youngest producer wins
	function automatic logic [`DATA_W-1:0] bypass(
		input logic [`REG_AW-1:0] src,
		input logic [`DATA_W-1:0] fromDec
	);
		if (src != '0 && rBus.valid && rBus.dest == src)
			return rBus.value;
		if (src != '0 && wrEn && wrAddr == src)
			return wrData;
		return fromDec;
	endfunction

	always_comb a = bypass(dBus.srcA, dBus.opA);
	always_comb b = bypass(dBus.srcB, dBus.opB);

	assign sum = a + b;
	assign diff = a - b;
	assign addOv = (a[`DATA_W-1] == b[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
	assign subOv = (a[`DATA_W-1] != b[`DATA_W-1]) && (diff[`DATA_W-1] != a[`DATA_W-1]);
	assign ovf = dBus.trapsOv && ((dBus.op == opSub) ? subOv : addOv);

	always_comb begin
		case (dBus.op)
			opAdd, opAddu: aluOut = sum;
			opSub: aluOut = diff;
			opAnd: aluOut = a & b;
			opOr: aluOut = a | b;
			opXor: aluOut = a ^ b;
			opSlt: aluOut = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
			opSll: aluOut = b << a[4:0]; // shamt rides in opA
			opLui: aluOut = {b[15:0], 16'h0000};
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		if (!dBus.valid)
			excNext = excNone;
		else if (dBus.ri)
			excNext = excRi;
		else if (ovf)
			excNext = excOv;
		else
			excNext = excNone;
	end

	always_ff @(posedge clk)
		if (!rst || squash) begin
			rBus.valid <= 1'b0;
			rBus.dest <= '0;
			rBus.value <= '0;
			rBus.exc <= excNone;
			rBus.pc <= '0;
		end else begin
			rBus.valid <= dBus.valid;
			rBus.dest <= dBus.dest;
			rBus.value <= aluOut;
			rBus.exc <= excNext;
			rBus.pc <= dBus.pc;
		end

	// decode must not hand over a reserved encoding with a real op
	riHasNoOp: assert property (@(posedge clk) disable iff (!rst)
		dBus.valid && dBus.ri |-> dBus.op == opNone)
		else $error("reserved instruction decoded with an op");

endmodule

/* verilog/resultStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module resultStage (
	input logic clk,
	input logic rst,
	resultBus.dst rBus,
	output logic squash,
	output logic wrEn,
	output logic [`REG_AW-1:0] wrAddr,
	output logic [`DATA_W-1:0] wrData,
	output logic retireValid,
	output logic [`REG_AW-1:0] retireReg,
	output logic [`DATA_W-1:0] retireData,
	output logic excValid,
	output corePkg::excCode_t excCode,
	output logic [`DATA_W-1:0] badVAddr
);
	import corePkg::*;

	logic excepting;
	logic retiring;

	assign excepting = rBus.valid && rBus.exc != excNone;
	assign retiring = rBus.valid && rBus.exc == excNone;
	assign squash = excepting; // kills the younger entries in D and E

	always_ff @(posedge clk)
		if (!rst) begin
			retireValid <= 1'b0;
			retireReg <= '0;
			retireData <= '0;
			excValid <= 1'b0;
			excCode <= excNone;
			badVAddr <= '0;
		end else begin
			retireValid <= retiring;
			retireReg <= retiring ? rBus.dest : '0;
			retireData <= retiring ? rBus.value : '0;
			excValid <= excepting;
			excCode <= excepting ? rBus.exc : excNone;
			badVAddr <= excepting ? rBus.pc : '0;
		end

	// writeback straight from the retirement register
	assign wrEn = retireValid && retireReg != '0;
	assign wrAddr = retireReg;
	assign wrData = retireData;

	// the entry right behind an exception must be gone
	squashClears: assert property (@(posedge clk) disable iff (!rst) squash |=> !rBus.valid)
		else $error("entry behind an exception was not squashed");

endmodule

/* verilog/miniCore.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module miniCore (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [`DATA_W-1:0] instr,
	input logic [`DATA_W-1:0] pc,
	output logic retireValid,
	output logic [`REG_AW-1:0] retireReg,
	output logic [`DATA_W-1:0] retireData,
	output logic excValid,
	output corePkg::excCode_t excCode,
	output logic [`DATA_W-1:0] badVAddr
);
	logic squash;
	logic wrEn;
	logic [`REG_AW-1:0] wrAddr;
	logic [`DATA_W-1:0] wrData;

	decodeBus dBus ();
	resultBus rBus ();

	decodeStage decodeStage_inst (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.squash(squash),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.dBus(dBus.src)
	);

	executeStage executeStage_inst (
		.clk(clk),
		.rst(rst),
		.dBus(dBus.dst),
		.squash(squash),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rBus(rBus.src)
	);

	resultStage resultStage_inst (
		.clk(clk),
		.rst(rst),
		.rBus(rBus.dst),
		.squash(squash),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData),
		.excValid(excValid),
		.excCode(excCode),
		.badVAddr(badVAddr)
	);

endmodule

/* sim/miniCoreTb.sv */
`timescale 1ns/1ps

module miniCoreTb;

	localparam int NFIXED = 36;
	localparam int NRAND = 24;
	localparam int NROWS = NFIXED + NRAND;
	localparam int TIMEOUT = NROWS * 4 + 50;

	typedef struct packed {
		logic isExc;
		logic [4:0] rg;
		logic [31:0] data;
		logic [4:0] code;
		logic [31:0] pc;
		int cyc; // cycle the strobe must show up in
		int row;
	} expEntry_t;

	logic clk = 1'b0;
	logic rst;
	logic instrValid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic retireValid;
	logic [4:0] retireReg;
	logic [31:0] retireData;
	logic excValid;
	logic [4:0] excCode;
	logic [31:0] badVAddr;

	logic [31:0] instrTab [NROWS];
	int gapTab [NROWS];
	string nameTab [NROWS];
	int nRows = 0;
	logic [31:0] regModel [32];
	expEntry_t expQ [$];
	int lastExcCyc = -100;
	logic [31:0] rngState = 32'h854;
	int cyc = 0;
	int valErrs = 0;
	int otherErrs = 0;

	miniCore miniCore_inst (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData),
		.excValid(excValid),
		.excCode(excCode),
		.badVAddr(badVAddr)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (cyc >= TIMEOUT) begin
			$display("timeout after %0d cycles, %0d results never appeared", cyc, expQ.size());
			$display("TESTS FAILED");
			$finish;
		end else
			cyc <= cyc + 1;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] sllInstr(input logic [4:0] rd, input logic [4:0] rt,
		input logic [4:0] sh);
		return {6'h00, 5'd0, rt, rd, sh, 6'h00};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic logic [31:0] pcOf(input int row);
		return 32'h0040_0000 + (row << 2);
	endfunction

	task automatic addRow(input logic [31:0] ins, input int gap, input string nm);
		instrTab[nRows] = ins;
		gapTab[nRows] = gap;
		nameTab[nRows] = nm;
		nRows++;
	endtask

	task automatic buildTable();
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] ins;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		addRow(iType(6'h0f, 5'd1, 5'd0, 16'h7fff), 4, "lui");
		addRow(iType(6'h0d, 5'd1, 5'd1, 16'hffff), 4, "ori");
		addRow(iType(6'h0d, 5'd2, 5'd0, 16'h1234), 4, "ori");
		addRow(iType(6'h08, 5'd3, 5'd0, 16'hfffe), 4, "addi");
		addRow(rType(6'h20, 5'd4, 5'd2, 5'd3), 4, "add");
		addRow(rType(6'h21, 5'd5, 5'd1, 5'd2), 4, "addu");
		addRow(rType(6'h22, 5'd6, 5'd2, 5'd3), 4, "sub");
		addRow(rType(6'h24, 5'd7, 5'd1, 5'd3), 4, "and");
		addRow(rType(6'h25, 5'd8, 5'd2, 5'd3), 4, "or");
		addRow(rType(6'h26, 5'd9, 5'd1, 5'd2), 4, "xor");
		addRow(rType(6'h2a, 5'd10, 5'd3, 5'd2), 4, "sltTrue");
		addRow(rType(6'h2a, 5'd11, 5'd2, 5'd3), 4, "sltFalse");
		addRow(sllInstr(5'd12, 5'd2, 5'd4), 4, "sll");
		addRow(iType(6'h08, 5'd13, 5'd2, 16'h0001), 1, "fwdSrc");
		addRow(rType(6'h20, 5'd14, 5'd13, 5'd13), 1, "fwd1");
		addRow(rType(6'h26, 5'd15, 5'd13, 5'd14), 1, "fwd2");
		addRow(rType(6'h22, 5'd16, 5'd13, 5'd15), 4, "fwd3");
		addRow(iType(6'h0d, 5'd17, 5'd0, 16'h00aa), 1, "olderWrite");
		addRow(iType(6'h0d, 5'd17, 5'd0, 16'h0055), 1, "youngerWrite");
		addRow(rType(6'h21, 5'd18, 5'd17, 5'd17), 4, "youngestWins");
		addRow(rType(6'h20, 5'd2, 5'd1, 5'd1), 4, "addOv");
		addRow(rType(6'h21, 5'd19, 5'd1, 5'd1), 4, "adduNoOv");
		addRow(rType(6'h25, 5'd21, 5'd2, 5'd0), 4, "ovKeepsDest");
		addRow(iType(6'h0f, 5'd23, 5'd0, 16'h8000), 4, "lui");
		addRow(rType(6'h22, 5'd24, 5'd23, 5'd2), 4, "subOv");
		addRow(iType(6'h08, 5'd1, 5'd1, 16'h0001), 4, "addiOv");
		addRow(rType(6'h21, 5'd25, 5'd1, 5'd0), 4, "ovKeepsDest");
		addRow(32'hfc00_0000, 1, "reservedOpcode");
		addRow(iType(6'h0d, 5'd2, 5'd0, 16'h0001), 1, "squashed");
		addRow(iType(6'h08, 5'd21, 5'd0, 16'h0002), 1, "squashed");
		addRow(iType(6'h0f, 5'd2, 5'd0, 16'h0003), 1, "squashed");
		addRow(iType(6'h0d, 5'd28, 5'd0, 16'h0004), 1, "afterSquash");
		addRow(rType(6'h25, 5'd29, 5'd2, 5'd21), 4, "afterSquash");
		addRow(32'h0000_003f, 4, "reservedFunct");
		addRow(iType(6'h08, 5'd0, 5'd0, 16'h0005), 1, "r0Write");
		addRow(rType(6'h25, 5'd30, 5'd0, 5'd0), 4, "r0Read");
		// random rows stay on r1..r15, which all hold known values by now
		for (int i = 0; i < NRAND; i++) begin
			rngState = lcg(rngState);
			r = rngState;
			rngState = lcg(rngState);
			s = rngState;
			rd = 5'd1 + ({1'b0, r[31:28]} % 5'd15);
			rs = 5'd1 + ({1'b0, r[27:24]} % 5'd15);
			rt = 5'd1 + ({1'b0, r[23:20]} % 5'd15);
			case (r[19:16] % 4'd11)
				4'd0: ins = rType(6'h20, rd, rs, rt);
				4'd1: ins = rType(6'h21, rd, rs, rt);
				4'd2: ins = rType(6'h22, rd, rs, rt);
				4'd3: ins = rType(6'h24, rd, rs, rt);
				4'd4: ins = rType(6'h25, rd, rs, rt);
				4'd5: ins = rType(6'h26, rd, rs, rt);
				4'd6: ins = rType(6'h2a, rd, rs, rt);
				4'd7: ins = sllInstr(rd, rt, s[20:16]);
				4'd8: ins = iType(6'h08, rd, rs, s[31:16]);
				4'd9: ins = iType(6'h0d, rd, rs, s[31:16]);
				default: ins = iType(6'h0f, rd, 5'd0, s[31:16]);
			endcase
			addRow(ins, 1 + int'(s[15:14]), "random");
		end
	endtask

	// in-order ISA model, plus the +1..+3 squash window after an exception
	task automatic predict(input int row, input int issueCyc);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] res;
		logic [32:0] wide;
		logic [4:0] dst;
		logic [4:0] code;
		expEntry_t e;
		if (issueCyc - lastExcCyc <= 3)
			return;
		ins = instrTab[row];
		a = regModel[ins[25:21]];
		b = regModel[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		dst = ins[15:11];
		res = 32'd0;
		code = 5'd0;
		wide = 33'd0;
		case (ins[31:26])
			6'h00: begin
				case (ins[5:0])
					6'h20: wide = {a[31], a} + {b[31], b};
					6'h21: res = a + b;
					6'h22: wide = {a[31], a} - {b[31], b};
					6'h24: res = a & b;
					6'h25: res = a | b;
					6'h26: res = a ^ b;
					6'h2a: res = {31'd0, $signed(a) < $signed(b)};
					6'h00: res = b << ins[10:6];
					default: code = 5'd10;
				endcase
				if (ins[5:0] == 6'h20 || ins[5:0] == 6'h22) begin
					res = wide[31:0];
					if (wide[32] != wide[31])
						code = 5'd12;
				end
			end
			6'h08: begin
				dst = ins[20:16];
				wide = {a[31], a} + {simm[31], simm};
				res = wide[31:0];
				if (wide[32] != wide[31])
					code = 5'd12;
			end
			6'h0d: begin
				dst = ins[20:16];
				res = a | {16'h0000, ins[15:0]};
			end
			6'h0f: begin
				dst = ins[20:16];
				res = {ins[15:0], 16'h0000};
			end
			default: code = 5'd10;
		endcase
		e.isExc = (code != 5'd0);
		e.rg = dst;
		e.data = res;
		e.code = code;
		e.pc = pcOf(row);
		e.cyc = issueCyc + 3;
		e.row = row;
		expQ.push_back(e);
		if (e.isExc)
			lastExcCyc = issueCyc;
		else if (dst != 5'd0)
			regModel[dst] = res;
	endtask

	task automatic compareValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("Error %s: expected %h, actual %h", name, expVal, actVal);
			valErrs++;
		end
	endtask

	always @(negedge clk) begin : monitor
		expEntry_t e;
		string nm;
		if (rst) begin
			if (retireValid || excValid) begin
				if (expQ.size() == 0) begin
					$display("output strobe at cycle %0d with no instruction outstanding", cyc);
					otherErrs++;
				end else begin
					e = expQ.pop_front();
					nm = $sformatf("%s#%0d", nameTab[e.row], e.row);
					compareValue({nm, " cycle"}, e.cyc, cyc);
					compareValue({nm, " excValid"}, {31'd0, e.isExc}, {31'd0, excValid});
					compareValue({nm, " retireValid"}, {31'd0, !e.isExc}, {31'd0, retireValid});
					if (e.isExc) begin
						compareValue({nm, " excCode"}, {27'd0, e.code}, {27'd0, excCode});
						compareValue({nm, " badVAddr"}, e.pc, badVAddr);
					end else begin
						compareValue({nm, " retireReg"}, {27'd0, e.rg}, {27'd0, retireReg});
						compareValue({nm, " retireData"}, e.data, retireData);
					end
				end
			end else begin
				if (retireReg != 5'd0 || retireData != 32'd0 || excCode != 5'd0
					|| badVAddr != 32'd0) begin
					$display("outputs not idle at cycle %0d", cyc);
					otherErrs++;
				end
				if (expQ.size() != 0 && expQ[0].cyc <= cyc) begin
					$display("%s#%0d never reached the outputs in cycle %0d",
						nameTab[expQ[0].row], expQ[0].row, expQ[0].cyc);
					otherErrs++;
					e = expQ.pop_front();
				end
			end
		end
	end

	initial begin : stimulus
		int g;
		rst = 1'b0;
		instrValid = 1'b0;
		instr = 32'd0;
		pc = 32'd0;
		regModel[0] = 32'd0;
		buildTable();
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		for (int r = 0; r < NROWS; r++) begin
			@(posedge clk);
			instrValid <= 1'b1;
			instr <= instrTab[r];
			pc <= pcOf(r);
			predict(r, cyc + 1); // cyc still holds the count before this edge
			for (g = 1; g < gapTab[r]; g++) begin
				@(posedge clk);
				instrValid <= 1'b0;
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk); // catch late strays
		$display("%0d value errors, %0d other errors", valErrs, otherErrs);
		if (valErrs + otherErrs == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verilog
verilog/corePkg.sv
verilog/stageBus.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/miniCore.sv
sim/miniCoreTb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log \
	&& verilator --binary --assert -f vlog.f --top-module miniCoreTb -o miniCoreSim > build.log 2>&1 \
	&& ./obj_dir/miniCoreSim > sim.log 2>&1 \
	|| echo "build or simulation did not complete, see build.log"
grep -q "TESTS PASSED" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
